/* design/bridge_pkg.sv */
package bridge_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // FSM encodings
    ////////////////////////////////////////////////////////////////////////////

    // read address channel
    typedef enum logic {
        AR_IDLE, // waiting for a cache read
        AR_SEND  // arvalid up, holding payload
    } ar_state_e;

    // write address, data and response, one write at a time
    typedef enum logic [2:0] {
        W_IDLE,      // wr_rdy high
        W_SEND_BOTH, // aw and w both pending
        W_SEND_ADDR, // w done, aw still pending
        W_SEND_DATA, // aw done, w still pending
        W_WAIT_RESP  // both done, bready up
    } w_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // cache request types
    ////////////////////////////////////////////////////////////////////////////

    // byte/half/word match the axi size code, line is a burst
    typedef enum logic [2:0] {
        RD_BYTE = 3'd0,
        RD_HALF = 3'd1,
        RD_WORD = 3'd2,
        RD_LINE = 3'd4
    } rd_type_e;

    ////////////////////////////////////////////////////////////////////////////
    // axi encodings
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned ID_ICACHE = 0; // instruction fetch
    localparam int unsigned ID_DCACHE = 1; // data access

    localparam logic [2:0] SIZE_WORD = 3'd2; // 4 bytes per beat

endpackage

/* design/read_req_arbiter.sv */
`timescale 1ns/10ps

module read_req_arbiter #(
    parameter int ADDR_W     = 32,
    parameter int ID_W       = 4,
    parameter int LINE_BEATS = 4,
    parameter int OUTST_W    = 2
) (
    input  logic                 aclk,
    input  logic                 aresetn,
    // instruction cache
    input  logic                 icache_rd_req,
    input  bridge_pkg::rd_type_e icache_rd_type,
    input  logic [ADDR_W-1:0]    icache_rd_addr,
    output logic                 icache_rd_rdy,
    // data cache
    input  logic                 dcache_rd_req,
    input  bridge_pkg::rd_type_e dcache_rd_type,
    input  logic [ADDR_W-1:0]    dcache_rd_addr,
    output logic                 dcache_rd_rdy,
    // ar channel
    output logic [ID_W-1:0]      arid,
    output logic [ADDR_W-1:0]    araddr,
    output logic [7:0]           arlen,
    output logic [2:0]           arsize,
    output logic                 arvalid,
    input  logic                 arready,
    // r channel, observed only
    input  logic                 rvalid,
    input  logic                 rready,
    input  logic                 rlast,
    // from the write side
    input  logic                 write_pending,
    input  logic [ADDR_W-1:0]    write_addr,
    output logic                 read_outstanding
);
    import bridge_pkg::*;

    ar_state_e          ar_state;
    logic [OUTST_W-1:0] rd_cnt;     // reads in flight
    logic [ADDR_W-1:0]  grant_addr;
    rd_type_e           grant_type;
    logic               raw_hazard;
    logic               cnt_full;
    logic               accept;
    logic               ar_hs;
    logic               r_done;

    ////////////////////////////////////////////////////////////////////////////
    // grant, dcache first
    ////////////////////////////////////////////////////////////////////////////

    assign grant_addr = dcache_rd_req ? dcache_rd_addr : icache_rd_addr;
    assign grant_type = dcache_rd_req ? dcache_rd_type : icache_rd_type;

    // read to a write still in flight must wait for bresp
    assign raw_hazard = write_pending && (grant_addr == write_addr);
    assign cnt_full   = &rd_cnt;

    // dcache read only when the return path is empty
    assign dcache_rd_rdy = (ar_state == AR_IDLE) && !raw_hazard && (rd_cnt == '0);
    assign icache_rd_rdy = (ar_state == AR_IDLE) && !dcache_rd_req && !raw_hazard
                           && !cnt_full;

    assign accept = (dcache_rd_req && dcache_rd_rdy) || (icache_rd_req && icache_rd_rdy);
    assign ar_hs  = arvalid && arready;
    assign r_done = rvalid && rready && rlast;   // one read retired

    ////////////////////////////////////////////////////////////////////////////
    // ar fsm and payload
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ar_state <= AR_IDLE;
        end else if (ar_state == AR_IDLE && accept) begin
            ar_state <= AR_SEND;
        end else if (ar_state == AR_SEND && arready) begin
            ar_state <= AR_IDLE;                 // back to idle right after handshake
        end
    end

    assign arvalid = (ar_state == AR_SEND);

    // payload only loads in idle, so it holds while arvalid waits
    always_ff @(posedge aclk) begin
        if (accept) begin
            arid   <= dcache_rd_req ? ID_W'(ID_DCACHE) : ID_W'(ID_ICACHE);
            araddr <= grant_addr;
            arlen  <= (grant_type == RD_LINE) ? 8'(LINE_BEATS - 1) : 8'd0;
            arsize <= SIZE_WORD;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // outstanding reads
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rd_cnt <= '0;
        end else if (ar_hs && !r_done) begin
            rd_cnt <= rd_cnt + 1'b1;
        end else if (r_done && !ar_hs) begin
            rd_cnt <= rd_cnt - 1'b1;
        end                                      // both at once, no change
    end

    assign read_outstanding = |rd_cnt;

    a_ar_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid)
                                && $stable(arlen));

    a_cnt_no_wrap: assert property (@(posedge aclk) disable iff (!aresetn)
        !(cnt_full && ar_hs && !r_done) && !((rd_cnt == '0) && r_done && !ar_hs));

endmodule

/* design/write_channel_ctrl.sv */
`timescale 1ns/10ps

module write_channel_ctrl #(
    parameter int ADDR_W = 32,
    parameter int DATA_W = 32
) (
    input  logic                 aclk,
    input  logic                 aresetn,
    // data cache write
    input  logic                 dcache_wr_req,
    input  bridge_pkg::rd_type_e dcache_wr_type,
    input  logic [ADDR_W-1:0]    dcache_wr_addr,
    input  logic [DATA_W/8-1:0]  dcache_wr_wstrb,
    input  logic [DATA_W-1:0]    dcache_wr_data,
    output logic                 dcache_wr_rdy,
    // aw channel
    output logic [ADDR_W-1:0]    awaddr,
    output logic [2:0]           awsize,
    output logic                 awvalid,
    input  logic                 awready,
    // w channel
    output logic [DATA_W-1:0]    wdata,
    output logic [DATA_W/8-1:0]  wstrb,
    output logic                 wvalid,
    input  logic                 wready,
    // b channel
    input  logic                 bvalid,
    output logic                 bready,
    // to the read side for the hazard check
    output logic                 write_pending,
    output logic [ADDR_W-1:0]    write_addr
);
    import bridge_pkg::*;

    w_state_e w_state;
    w_state_e w_next;
    logic     aw_hs;
    logic     w_hs;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;

    ////////////////////////////////////////////////////////////////////////////
    // write fsm
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        w_next = w_state;
        case (w_state)
            W_IDLE: begin
                if (dcache_wr_req) w_next = W_SEND_BOTH;
            end
            W_SEND_BOTH: begin                   // aw and w in either order
                if (aw_hs && w_hs)
                    w_next = W_WAIT_RESP;
                else if (aw_hs)
                    w_next = W_SEND_DATA;
                else if (w_hs)
                    w_next = W_SEND_ADDR;
            end
            W_SEND_ADDR: begin
                if (aw_hs) w_next = W_WAIT_RESP;
            end
            W_SEND_DATA: begin
                if (w_hs) w_next = W_WAIT_RESP;
            end
            W_WAIT_RESP: begin
                if (bvalid) w_next = W_IDLE;     // bready is up in this state
            end
            default: w_next = W_IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            w_state <= W_IDLE;
        end else begin
            w_state <= w_next;
        end
    end

    // latch the write on acceptance, held until the next one
    always_ff @(posedge aclk) begin
        if (dcache_wr_req && dcache_wr_rdy) begin
            awaddr <= dcache_wr_addr;
            awsize <= dcache_wr_type;            // byte/half/word match axi size
            wdata  <= dcache_wr_data;
            wstrb  <= dcache_wr_wstrb;
        end
    end

    assign dcache_wr_rdy = (w_state == W_IDLE);
    assign awvalid       = (w_state == W_SEND_BOTH) || (w_state == W_SEND_ADDR);
    assign wvalid        = (w_state == W_SEND_BOTH) || (w_state == W_SEND_DATA);
    assign bready        = (w_state == W_WAIT_RESP);

    // busy from acceptance until bresp
    assign write_pending = (w_state != W_IDLE);
    assign write_addr    = awaddr;

    // bready only comes up right after the second of the aw and w handshakes
    a_bready_after_aw_w: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(bready) |-> $past(aw_hs || w_hs));

    a_w_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb));

endmodule

/* design/read_return_demux.sv */
`timescale 1ns/10ps

module read_return_demux #(
    parameter int DATA_W = 32,
    parameter int ID_W   = 4
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              read_outstanding,
    // r channel
    input  logic              rvalid,
    input  logic [ID_W-1:0]   rid,
    input  logic [DATA_W-1:0] rdata,
    input  logic              rlast,
    output logic              rready,
    // instruction cache return
    output logic              icache_ret_valid,
    output logic              icache_ret_last,
    output logic [DATA_W-1:0] icache_ret_data,
    // data cache return
    output logic              dcache_ret_valid,
    output logic              dcache_ret_last,
    output logic [DATA_W-1:0] dcache_ret_data
);
    import bridge_pkg::*;

    logic              r_hs;
    logic [DATA_W-1:0] beat_data;   // last accepted beat
    logic              beat_last;

    assign rready = read_outstanding;   // only take beats we asked for
    assign r_hs   = rvalid && rready;

    // beat capture
    always_ff @(posedge aclk) begin
        if (r_hs) begin
            beat_data <= rdata;
            beat_last <= rlast;
        end
    end

    // one-cycle pulse, steered by id
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            icache_ret_valid <= 1'b0;
            dcache_ret_valid <= 1'b0;
        end else begin
            icache_ret_valid <= r_hs && (rid == ID_W'(ID_ICACHE));
            dcache_ret_valid <= r_hs && (rid == ID_W'(ID_DCACHE));
        end
    end

    assign icache_ret_data = beat_data;
    assign dcache_ret_data = beat_data;
    assign icache_ret_last = beat_last && icache_ret_valid;
    assign dcache_ret_last = beat_last && dcache_ret_valid;

    a_ret_onehot: assert property (@(posedge aclk) disable iff (!aresetn)
        !(icache_ret_valid && dcache_ret_valid));

endmodule

/* design/cache_axi_bridge.sv */
`timescale 1ns/10ps

module cache_axi_bridge #(
    parameter int ADDR_W     = 32,
    parameter int DATA_W     = 32,
    parameter int ID_W       = 4,
    parameter int LINE_BEATS = 4,
    parameter int OUTST_W    = 2
) (
    input  logic                 aclk,
    input  logic                 aresetn,
    // instruction cache
    input  logic                 icache_rd_req,
    input  bridge_pkg::rd_type_e icache_rd_type,
    input  logic [ADDR_W-1:0]    icache_rd_addr,
    output logic                 icache_rd_rdy,
    output logic                 icache_ret_valid,
    output logic                 icache_ret_last,
    output logic [DATA_W-1:0]    icache_ret_data,
    // data cache
    input  logic                 dcache_rd_req,
    input  bridge_pkg::rd_type_e dcache_rd_type,
    input  logic [ADDR_W-1:0]    dcache_rd_addr,
    output logic                 dcache_rd_rdy,
    output logic                 dcache_ret_valid,
    output logic                 dcache_ret_last,
    output logic [DATA_W-1:0]    dcache_ret_data,
    input  logic                 dcache_wr_req,
    input  bridge_pkg::rd_type_e dcache_wr_type,
    input  logic [ADDR_W-1:0]    dcache_wr_addr,
    input  logic [DATA_W/8-1:0]  dcache_wr_wstrb,
    input  logic [DATA_W-1:0]    dcache_wr_data,
    output logic                 dcache_wr_rdy,
    // axi ar
    output logic [ID_W-1:0]      arid,
    output logic [ADDR_W-1:0]    araddr,
    output logic [7:0]           arlen,
    output logic [2:0]           arsize,
    output logic                 arvalid,
    input  logic                 arready,
    // axi r
    input  logic [ID_W-1:0]      rid,
    input  logic [DATA_W-1:0]    rdata,
    input  logic                 rlast,
    input  logic                 rvalid,
    output logic                 rready,
    // axi aw / w / b
    output logic [ADDR_W-1:0]    awaddr,
    output logic [2:0]           awsize,
    output logic                 awvalid,
    input  logic                 awready,
    output logic [DATA_W-1:0]    wdata,
    output logic [DATA_W/8-1:0]  wstrb,
    output logic                 wvalid,
    input  logic                 wready,
    input  logic                 bvalid,
    output logic                 bready
);

    logic              write_pending;     // write in flight, for raw check
    logic [ADDR_W-1:0] write_addr;
    logic              read_outstanding;

    read_req_arbiter #(
        .ADDR_W(ADDR_W), .ID_W(ID_W), .LINE_BEATS(LINE_BEATS), .OUTST_W(OUTST_W)
    ) u_read_req_arbiter (
        .aclk(aclk), .aresetn(aresetn),
        .icache_rd_req(icache_rd_req), .icache_rd_type(icache_rd_type),
        .icache_rd_addr(icache_rd_addr), .icache_rd_rdy(icache_rd_rdy),
        .dcache_rd_req(dcache_rd_req), .dcache_rd_type(dcache_rd_type),
        .dcache_rd_addr(dcache_rd_addr), .dcache_rd_rdy(dcache_rd_rdy),
        .arid(arid), .araddr(araddr), .arlen(arlen), .arsize(arsize),
        .arvalid(arvalid), .arready(arready),
        .rvalid(rvalid), .rready(rready), .rlast(rlast),
        .write_pending(write_pending), .write_addr(write_addr),
        .read_outstanding(read_outstanding)
    );

    write_channel_ctrl #(
        .ADDR_W(ADDR_W), .DATA_W(DATA_W)
    ) u_write_channel_ctrl (
        .aclk(aclk), .aresetn(aresetn),
        .dcache_wr_req(dcache_wr_req), .dcache_wr_type(dcache_wr_type),
        .dcache_wr_addr(dcache_wr_addr), .dcache_wr_wstrb(dcache_wr_wstrb),
        .dcache_wr_data(dcache_wr_data), .dcache_wr_rdy(dcache_wr_rdy),
        .awaddr(awaddr), .awsize(awsize), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready),
        .write_pending(write_pending), .write_addr(write_addr)
    );

    read_return_demux #(
        .DATA_W(DATA_W), .ID_W(ID_W)
    ) u_read_return_demux (
        .aclk(aclk), .aresetn(aresetn),
        .read_outstanding(read_outstanding),
        .rvalid(rvalid), .rid(rid), .rdata(rdata), .rlast(rlast), .rready(rready),
        .icache_ret_valid(icache_ret_valid), .icache_ret_last(icache_ret_last),
        .icache_ret_data(icache_ret_data),
        .dcache_ret_valid(dcache_ret_valid), .dcache_ret_last(dcache_ret_last),
        .dcache_ret_data(dcache_ret_data)
    );

endmodule

/* testbench/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter real PERIOD_NS  = 4.0,
    parameter int  RST_CYCLES = 5
) (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk = 1'b0;
        forever #(PERIOD_NS / 2.0) aclk = ~aclk;   // free running
    end

    // reset low for a fixed number of edges, released off the edge
    initial begin
        aresetn = 1'b0;
        repeat (RST_CYCLES) @(posedge aclk);
        #1 aresetn = 1'b1;
    end

endmodule

/* testbench/axi_slave_model.sv */
`timescale 1ns/10ps

module axi_slave_model #(
    parameter int ID_W = 4
) (
    input  logic          aclk,
    input  logic          stall_en,   // random ready/valid gaps
    input  int            b_extra,    // extra cycles before bvalid
    input  logic [ID_W-1:0] arid,
    input  logic [31:0]   araddr,
    input  logic [7:0]    arlen,
    input  logic          arvalid,
    output logic          arready,
    output logic [ID_W-1:0] rid,
    output logic [31:0]   rdata,
    output logic          rlast,
    output logic          rvalid,
    input  logic          rready,
    input  logic [31:0]   awaddr,
    input  logic          awvalid,
    output logic          awready,
    input  logic [31:0]   wdata,
    input  logic [3:0]    wstrb,
    input  logic          wvalid,
    output logic          wready,
    output logic          bvalid,
    input  logic          bready
);

    logic [31:0]     mem [256];
    logic [31:0]     lfsr = 32'h7f02;
    logic [ID_W-1:0] q_id [$];        // accepted reads, served in order
    logic [31:0]     q_addr [$];
    logic [7:0]      q_len [$];

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic next_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic int pick_stall();
        int n;
        n = 0;
        if (stall_en) begin
            for (int i = 0; i < 3; i++) n = (n << 1) | next_bit();   // 0..7
        end
        return n;
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) mem[i] = (i << 2) ^ 32'hA5A5_0000;
    end

    ////////////////////////////////////////////////////////////////////////////
    // read address, then beats in order of acceptance
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int n;
        arready = 1'b0;
        forever begin
            @(posedge aclk);
            if (arvalid) begin
                n = pick_stall();
                repeat (n) @(posedge aclk);
                #1 arready = 1'b1;
                @(posedge aclk);                 // arvalid is held, handshake here
                q_id.push_back(arid);
                q_addr.push_back(araddr);
                q_len.push_back(arlen);
                #1 arready = 1'b0;
            end
        end
    end

    initial begin
        int n;
        logic [31:0] a;
        logic [7:0]  len;
        rvalid = 1'b0;
        rid    = '0;
        rdata  = '0;
        rlast  = 1'b0;
        forever begin
            @(posedge aclk);
            if (q_id.size() != 0) begin
                #1;
                a   = q_addr[0];
                len = q_len[0];
                rid = q_id.pop_front();
                void'(q_addr.pop_front());
                void'(q_len.pop_front());
                for (int b = 0; b <= len; b++) begin
                    n = pick_stall();
                    if (n > 0) begin
                        rvalid = 1'b0;
                        repeat (n) @(posedge aclk);
                        #1;
                    end
                    rvalid = 1'b1;
                    rdata  = mem[8'(a[9:2] + b)];   // incrementing burst
                    rlast  = (b == len);
                    do @(posedge aclk); while (!rready);
                    #1;
                end
                rvalid = 1'b0;
                rlast  = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // write: aw and w independently, then b
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int          n;
        logic [31:0] wa;
        logic [31:0] wd;
        logic [3:0]  ws;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        forever begin
            @(posedge aclk);
            if (awvalid || wvalid) begin
                fork
                    begin
                        repeat (pick_stall()) @(posedge aclk);
                        #1 awready = 1'b1;
                        @(posedge aclk);
                        wa = awaddr;
                        #1 awready = 1'b0;
                    end
                    begin
                        repeat (pick_stall()) @(posedge aclk);
                        #1 wready = 1'b1;
                        @(posedge aclk);
                        wd = wdata;
                        ws = wstrb;
                        #1 wready = 1'b0;
                    end
                join
                for (int k = 0; k < 4; k++) begin
                    if (ws[k]) mem[wa[9:2]][8*k +: 8] = wd[8*k +: 8];
                end
                n = pick_stall() + b_extra;
                if (n > 0) begin
                    repeat (n) @(posedge aclk);
                    #1;
                end
                bvalid = 1'b1;
                do @(posedge aclk); while (!bready);
                #1 bvalid = 1'b0;
            end
        end
    end

endmodule

/* testbench/tb_cache_axi_bridge.sv */
`timescale 1ns/10ps

module tb_cache_axi_bridge;
    import bridge_pkg::*;

    localparam int N_TRANS     = 60;
    localparam int MAX_TXN_CYC = 40;
    localparam int TIMEOUT_CYC = N_TRANS * MAX_TXN_CYC + 1600;   // 4000

    logic aclk, aresetn;
    logic icache_rd_req, icache_rd_rdy, icache_ret_valid, icache_ret_last;
    rd_type_e icache_rd_type, dcache_rd_type, dcache_wr_type;
    logic [31:0] icache_rd_addr, icache_ret_data, dcache_rd_addr, dcache_ret_data;
    logic dcache_rd_req, dcache_rd_rdy, dcache_ret_valid, dcache_ret_last;
    logic dcache_wr_req, dcache_wr_rdy;
    logic [31:0] dcache_wr_addr, dcache_wr_data;
    logic [3:0]  dcache_wr_wstrb, wstrb;
    logic [3:0]  arid, rid;
    logic [31:0] araddr, rdata, awaddr, wdata;
    logic [7:0]  arlen;
    logic [2:0]  arsize, awsize;
    logic arvalid, arready, rlast, rvalid, rready;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic stall_en;
    int   b_extra;

    logic [31:0] ref_mem [256];
    logic [31:0] exp_i_data [$], exp_d_data [$], exp_ar_addr [$], exp_w [$];
    bit          exp_i_last [$], exp_d_last [$];
    logic [3:0]  exp_ar_id [$];
    logic [7:0]  exp_ar_len [$];
    logic [31:0] wr_addr_tb;     // last write still waiting for b
    bit          wr_busy;
    int          rd_inflight, i_last_cnt, cycle, err_cnt, test_cnt, fail_cnt, err_mark;
    time         i_acc_t, d_acc_t;

    tb_clk_gen #(.PERIOD_NS(4.0), .RST_CYCLES(5)) u_clk (.aclk(aclk), .aresetn(aresetn));

    cache_axi_bridge u_cache_axi_bridge (.*);

    axi_slave_model u_slave (.*);

    task automatic show_mismatch(string name, logic [31:0] exp, logic [31:0] act);
        $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, exp, act);
        err_cnt++;
    endtask

    task automatic show_problem(string what);
        $display("%0t ns: %s", $time, what);
        err_cnt++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // cache side requests, called #1 after an edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic issue_iread(rd_type_e t, logic [31:0] a);
        icache_rd_req  = 1'b1;
        icache_rd_type = t;
        icache_rd_addr = a;
        do @(posedge aclk); while (!icache_rd_rdy);
        for (int b = 0; b < ((t == RD_LINE) ? 4 : 1); b++) begin
            exp_i_data.push_back(ref_mem[8'(a[9:2] + b)]);
            exp_i_last.push_back(b == ((t == RD_LINE) ? 3 : 0));
        end
        exp_ar_id.push_back(4'(ID_ICACHE));
        exp_ar_addr.push_back(a);
        exp_ar_len.push_back((t == RD_LINE) ? 8'd3 : 8'd0);
        rd_inflight++;
        i_acc_t = $time;
        #1 icache_rd_req = 1'b0;
    endtask

    task automatic issue_dread(logic [31:0] a);
        dcache_rd_req  = 1'b1;
        dcache_rd_type = RD_WORD;
        dcache_rd_addr = a;
        do @(posedge aclk); while (!dcache_rd_rdy);
        exp_d_data.push_back(ref_mem[a[9:2]]);
        exp_d_last.push_back(1'b1);
        exp_ar_id.push_back(4'(ID_DCACHE));
        exp_ar_addr.push_back(a);
        exp_ar_len.push_back(8'd0);
        rd_inflight++;
        d_acc_t = $time;
        #1 dcache_rd_req = 1'b0;
    endtask

    task automatic issue_write(logic [31:0] a, logic [31:0] d, logic [3:0] s);
        dcache_wr_req   = 1'b1;
        dcache_wr_type  = RD_WORD;
        dcache_wr_addr  = a;
        dcache_wr_data  = d;
        dcache_wr_wstrb = s;
        do @(posedge aclk); while (!dcache_wr_rdy);
        for (int k = 0; k < 4; k++) begin
            if (s[k]) ref_mem[a[9:2]][8*k +: 8] = d[8*k +: 8];   // reference copy
        end
        exp_w.push_back(a);
        exp_w.push_back(d);
        exp_w.push_back(32'(s));
        wr_busy = 1'b1;
        wr_addr_tb = a;
        #1 dcache_wr_req = 1'b0;
    endtask

    // polled off the edge, after the monitor has retired this cycle's beats
    task automatic wait_all_done();
        do begin
            @(posedge aclk);
            #1;
        end while (exp_i_data.size() || exp_d_data.size() || exp_ar_id.size() || wr_busy);
    endtask

    task automatic close_test(string name);
        test_cnt++;
        if (err_cnt != err_mark) fail_cnt++;
        $display("test %0d %s: %s", test_cnt, name, (err_cnt != err_mark) ? "fail" : "ok");
        err_mark = err_cnt;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // monitors
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        wait (cycle >= TIMEOUT_CYC);
        $display("run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("TB FAILED");
        $finish;
    end

    always @(posedge aclk) begin
        cycle++;
        if (arvalid && arready) begin
            if (exp_ar_id.size() == 0) show_problem("AR handshake with no request");
            else begin
                assert (arid == exp_ar_id[0]) else show_mismatch("arid", exp_ar_id[0], arid);
                assert (araddr == exp_ar_addr[0])
                    else show_mismatch("araddr", exp_ar_addr[0], araddr);
                assert (arlen == exp_ar_len[0])
                    else show_mismatch("arlen", exp_ar_len[0], arlen);
                assert (arsize == SIZE_WORD) else show_mismatch("arsize", SIZE_WORD, arsize);
                void'(exp_ar_id.pop_front());
                void'(exp_ar_addr.pop_front());
                void'(exp_ar_len.pop_front());
            end
        end
        if (awvalid && awready) begin
            assert (awaddr == exp_w[0]) else show_mismatch("awaddr", exp_w[0], awaddr);
            assert (awsize == SIZE_WORD) else show_mismatch("awsize", SIZE_WORD, awsize);
        end
        if (wvalid && wready) begin
            assert (wdata == exp_w[1]) else show_mismatch("wdata", exp_w[1], wdata);
            assert (wstrb == exp_w[2][3:0]) else show_mismatch("wstrb", exp_w[2], wstrb);
        end
        if (bvalid && bready) begin
            wr_busy = 1'b0;
            repeat (3) void'(exp_w.pop_front());
        end
        if (icache_ret_valid) begin
            if (exp_i_data.size() == 0) show_problem("icache return with nothing expected");
            else begin
                assert (icache_ret_data == exp_i_data[0])
                    else show_mismatch("icache_ret_data", exp_i_data[0], icache_ret_data);
                assert (icache_ret_last == exp_i_last[0])
                    else show_mismatch("icache_ret_last", exp_i_last[0], icache_ret_last);
                void'(exp_i_data.pop_front());
                void'(exp_i_last.pop_front());
            end
            if (icache_ret_last) begin
                i_last_cnt++;
                rd_inflight--;
            end
        end
        if (dcache_ret_valid) begin
            if (exp_d_data.size() == 0) show_problem("dcache return with nothing expected");
            else begin
                assert (dcache_ret_data == exp_d_data[0])
                    else show_mismatch("dcache_ret_data", exp_d_data[0], dcache_ret_data);
                assert (dcache_ret_last == exp_d_last[0])
                    else show_mismatch("dcache_ret_last", exp_d_last[0], dcache_ret_last);
                void'(exp_d_data.pop_front());
                void'(exp_d_last.pop_front());
            end
            if (dcache_ret_last) rd_inflight--;
        end
    end

    // wr_rdy comes back only through a b handshake
    a_wr_rdy_after_b: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(dcache_wr_rdy) |-> $past(bvalid && bready))
        else show_problem("dcache_wr_rdy rose without a write response");

    // no read of the written address before its bresp
    a_no_raw_read: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && arready && wr_busy |-> araddr != wr_addr_tb)
        else show_problem("read of a pending write address reached the AR channel");

    a_dread_waits: assert property (@(posedge aclk) disable iff (!aresetn)
        dcache_rd_req && dcache_rd_rdy |->
            (rd_inflight == 0) || (rd_inflight == 1 && (icache_ret_last || dcache_ret_last)))
        else show_problem("dcache read accepted while reads were outstanding");

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        icache_rd_req   = 1'b0;
        icache_rd_type  = RD_WORD;
        icache_rd_addr  = '0;
        dcache_rd_req   = 1'b0;
        dcache_rd_type  = RD_WORD;
        dcache_rd_addr  = '0;
        dcache_wr_req   = 1'b0;
        dcache_wr_type  = RD_WORD;
        dcache_wr_addr  = '0;
        dcache_wr_data  = '0;
        dcache_wr_wstrb = '0;
        stall_en        = 1'b0;
        b_extra         = 0;
        for (int i = 0; i < 256; i++) ref_mem[i] = (i << 2) ^ 32'hA5A5_0000;
        @(posedge aresetn);
        @(posedge aclk);
        #1;

        issue_iread(RD_LINE, 32'h40);
        wait_all_done();
        close_test("icache line read");

        fork
            issue_dread(32'h80);
            issue_iread(RD_WORD, 32'h90);
        join
        wait_all_done();
        if (d_acc_t >= i_acc_t) show_problem("icache read was granted before dcache read");
        close_test("dcache priority");

        issue_write(32'h100, 32'hDEAD_BEEF, 4'hf);
        wait_all_done();
        close_test("dcache write");

        b_extra = 12;                          // hold bvalid back
        issue_write(32'h104, 32'h1234_5678, 4'hf);
        issue_dread(32'h104);
        wait_all_done();
        b_extra = 0;
        close_test("read after write");

        stall_en = 1'b1;
        i_last_cnt = 0;
        fork
            for (int n = 0; n < 6; n++) begin
                issue_iread((n % 2) ? RD_WORD : RD_LINE, 32'h200 + 16 * n);
            end
            begin
                repeat (6) @(posedge aclk);
                #1 issue_dread(32'h20);
            end
        join
        wait_all_done();
        if (i_last_cnt != 6) show_mismatch("icache_ret_last count", 6, i_last_cnt);
        close_test("overlapped icache reads");

        $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
design/bridge_pkg.sv
design/read_req_arbiter.sv
design/write_channel_ctrl.sv
design/read_return_demux.sv
design/cache_axi_bridge.sv
testbench/tb_clk_gen.sv
testbench/axi_slave_model.sv
testbench/tb_cache_axi_bridge.sv

/* Bender.yml */
package:
  name: cache_axi_bridge

sources:
  - design/bridge_pkg.sv
  - design/read_req_arbiter.sv
  - design/write_channel_ctrl.sv
  - design/read_return_demux.sv
  - design/cache_axi_bridge.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/axi_slave_model.sv
      - testbench/tb_cache_axi_bridge.sv
